// File: verilog/pr_pkg.sv
package pr_pkg;

  ////////////////////
  // Widths

  localparam int SLOT_W  = 2;
  localparam int COUNT_W = 16;

  ////////////////////
  // Descriptor types

  typedef enum logic [1:0] {
    OP_PASS = 2'd0,
    OP_ADD  = 2'd1,
    OP_DUP  = 2'd2,
    OP_DROP = 2'd3
  } op_e;

  // 64-bit descriptor as it enters the cluster
  typedef struct packed {
    logic [SLOT_W-1:0] slot;
    op_e               op;
    logic [11:0]       tag;
    logic [15:0]       imm;
    logic [31:0]       payload;
  } desc_t;

  // Second copy flag sits above the descriptor
  typedef struct packed {
    logic  second;
    desc_t desc;
  } res_t;

  typedef struct packed {
    res_t res;
    logic valid;
  } res_ch_t;

endpackage

// File: verilog/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter int DATA_WIDTH = 64
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  clear,
  input  logic [DATA_WIDTH-1:0] s_data,
  input  logic                  s_valid,
  output logic                  s_ready,
  output logic [DATA_WIDTH-1:0] m_data,
  output logic                  m_valid,
  input  logic                  m_ready
);

  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_valid;
  logic                  s_fire;
  logic                  out_free;

  assign s_fire   = s_valid && s_ready;
  assign out_free = !m_valid || m_ready;

  // Ready is a flop, low until first cycle out of reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      s_ready    <= 1'b0;
    end else if (clear) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
      s_ready    <= 1'b1;
    end else if (out_free) begin
      m_valid    <= skid_valid || s_fire;
      skid_valid <= 1'b0;
      s_ready    <= 1'b1;
    end else if (s_fire) begin
      // Output stalled, park the extra item
      skid_valid <= 1'b1;
      s_ready    <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid) begin
        m_data <= skid_data;
      end else if (s_fire) begin
        m_data <= s_data;
      end
    end else if (s_fire) begin
      skid_data <= s_data;
    end
  end

  a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (m_valid && !m_ready && !clear) |=> $stable(m_data));

endmodule

// File: verilog/desc_engine.sv
`timescale 1ns/1ps

module desc_engine (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       clear,
  input  pr_pkg::desc_t              desc,
  input  logic                       desc_valid,
  output logic                       desc_ready,
  output pr_pkg::res_t               res,
  output logic                       res_valid,
  input  logic                       res_ready,
  output logic [pr_pkg::COUNT_W-1:0] count
);

  import pr_pkg::*;

  typedef enum logic {
    ST_IDLE,
    ST_SECOND
  } state_e;

  state_e state;
  logic   accept;
  res_t   res_d;

  // Take a new descriptor only when the result slot frees up
  assign desc_ready = (state == ST_IDLE) && (!res_valid || res_ready);
  assign accept     = desc_valid && desc_ready;

  always_comb begin
    res_d.second = 1'b0;
    res_d.desc   = desc;
    if (desc.op == OP_ADD) begin
      res_d.desc.payload = desc.payload + {16'd0, desc.imm};
    end
  end

  ////////////////////
  // Control

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= ST_IDLE;
      res_valid <= 1'b0;
      count     <= '0;
    end else if (clear) begin
      state     <= ST_IDLE;
      res_valid <= 1'b0;
      count     <= '0;
    end else begin
      if (accept) begin
        count <= count + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (accept) begin
            res_valid <= (desc.op != OP_DROP);
            if (desc.op == OP_DUP) begin
              state <= ST_SECOND;
            end
          end else if (res_ready) begin
            res_valid <= 1'b0;
          end
        end
        ST_SECOND: begin
          // First copy leaves, second one stays valid
          if (res_ready) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res <= res_d;
    end else if (state == ST_SECOND && res_ready) begin
      res.second <= 1'b1;
    end
  end

  a_no_spurious_res: assert property (@(posedge clk) disable iff (!arst_n)
    (state == ST_IDLE && $rose(res_valid)) |-> $past(accept));

endmodule

// File: verilog/core_wrapper.sv
`timescale 1ns/1ps

module core_wrapper (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       core_reset,
  input  pr_pkg::desc_t              desc,
  input  logic                       desc_valid,
  output logic                       desc_ready,
  output pr_pkg::res_t               res,
  output logic                       res_valid,
  input  logic                       res_ready,
  output logic [pr_pkg::COUNT_W-1:0] count
);

  import pr_pkg::*;

  logic               rst_n_r;
  logic               core_reset_r;
  desc_t              desc_r;
  logic               desc_valid_r;
  logic               desc_ready_r;
  res_t               res_n;
  logic               res_valid_n;
  logic               res_ready_n;
  logic [COUNT_W-1:0] count_n;

  ////////////////////
  // Boundary resets

  // Asserts at once, releases on the next edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_n_r <= 1'b0;
    end else begin
      rst_n_r <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n_r) begin
    if (!rst_n_r) begin
      core_reset_r <= 1'b0;
      count        <= '0;
    end else begin
      core_reset_r <= core_reset;
      count        <= count_n;
    end
  end

  ////////////////////
  // Descriptor ports

  pipe_reg #(
    .DATA_WIDTH($bits(desc_t))
  ) in_desc_reg (
    .clk     (clk),
    .arst_n  (rst_n_r),
    .clear   (core_reset_r),
    .s_data  (desc),
    .s_valid (desc_valid),
    .s_ready (desc_ready),
    .m_data  (desc_r),
    .m_valid (desc_valid_r),
    .m_ready (desc_ready_r)
  );

  desc_engine engine (
    .clk        (clk),
    .arst_n     (rst_n_r),
    .clear      (core_reset_r),
    .desc       (desc_r),
    .desc_valid (desc_valid_r),
    .desc_ready (desc_ready_r),
    .res        (res_n),
    .res_valid  (res_valid_n),
    .res_ready  (res_ready_n),
    .count      (count_n)
  );

  pipe_reg #(
    .DATA_WIDTH($bits(res_t))
  ) out_res_reg (
    .clk     (clk),
    .arst_n  (rst_n_r),
    .clear   (core_reset_r),
    .s_data  (res_n),
    .s_valid (res_valid_n),
    .s_ready (res_ready_n),
    .m_data  (res),
    .m_valid (res_valid),
    .m_ready (res_ready)
  );

endmodule

// File: verilog/desc_dispatch.sv
`timescale 1ns/1ps

module desc_dispatch #(
  parameter int NUM_CORES = 4
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  pr_pkg::desc_t        in_desc,
  input  logic                 in_valid,
  output logic                 in_ready,
  output pr_pkg::desc_t        slot_desc,
  output logic [NUM_CORES-1:0] slot_valid,
  input  logic [NUM_CORES-1:0] slot_ready
);

  import pr_pkg::*;

  // Every wrapper sees the descriptor, only one sees valid
  assign slot_desc = in_desc;

  always_comb begin
    slot_valid = '0;
    in_ready   = 1'b0;
    for (int i = 0; i < NUM_CORES; i++) begin
      if (in_desc.slot == SLOT_W'(i)) begin
        slot_valid[i] = in_valid;
        in_ready      = slot_ready[i];
      end
    end
  end

  // Unpopulated slot would hang the input forever
  a_slot_in_range: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> (int'(in_desc.slot) < NUM_CORES))
    else $error("descriptor for slot %0d, only %0d cores", in_desc.slot, NUM_CORES);

endmodule

// File: verilog/result_collect.sv
`timescale 1ns/1ps

module result_collect #(
  parameter int NUM_CORES = 4
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  pr_pkg::res_ch_t            res_ch [NUM_CORES],
  output logic [NUM_CORES-1:0]       res_ready,
  input  logic [pr_pkg::COUNT_W-1:0] counts [NUM_CORES],
  input  logic [pr_pkg::SLOT_W-1:0]  status_sel,
  output pr_pkg::res_t               out_res,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [pr_pkg::COUNT_W-1:0] status_count
);

  import pr_pkg::*;

  logic [SLOT_W-1:0] last;
  logic [SLOT_W-1:0] gnt_idx;
  logic              gnt_found;
  logic              load;

  // Output register can take a new result while draining
  assign load = !out_valid || out_ready;

  ////////////////////
  // Round-robin grant

  always_comb begin : arb
    int idx;
    gnt_idx   = last;
    gnt_found = 1'b0;
    for (int k = 1; k <= NUM_CORES; k++) begin
      idx = (int'(last) + k) % NUM_CORES;
      if (!gnt_found && res_ch[idx].valid) begin
        gnt_found = 1'b1;
        gnt_idx   = SLOT_W'(idx);
      end
    end
  end

  always_comb begin
    res_ready = '0;
    if (load && gnt_found) begin
      res_ready[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid    <= 1'b0;
      last         <= SLOT_W'(NUM_CORES - 1);
      status_count <= '0;
    end else begin
      if (load) begin
        out_valid <= gnt_found;
        if (gnt_found) begin
          last <= gnt_idx;
        end
      end
      status_count <= (int'(status_sel) < NUM_CORES) ? counts[status_sel] : '0;
    end
  end

  always_ff @(posedge clk) begin
    if (load && gnt_found) begin
      out_res <= res_ch[gnt_idx].res;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(res_ready));

endmodule

// File: verilog/pr_cluster_top.sv
`timescale 1ns/1ps

module pr_cluster_top #(
  parameter int NUM_CORES = 4
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  pr_pkg::desc_t              in_desc,
  input  logic                       in_valid,
  output logic                       in_ready,
  output pr_pkg::res_t               out_res,
  output logic                       out_valid,
  input  logic                       out_ready,
  input  logic [NUM_CORES-1:0]       core_reset,
  input  logic [pr_pkg::SLOT_W-1:0]  status_sel,
  output logic [pr_pkg::COUNT_W-1:0] status_count
);

  import pr_pkg::*;

  desc_t              slot_desc;
  logic [NUM_CORES-1:0] slot_valid;
  logic [NUM_CORES-1:0] slot_ready;
  res_ch_t            res_ch [NUM_CORES];
  logic [NUM_CORES-1:0] res_ready;
  logic [COUNT_W-1:0] counts [NUM_CORES];

  desc_dispatch #(
    .NUM_CORES (NUM_CORES)
  ) dispatch (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_desc    (in_desc),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .slot_desc  (slot_desc),
    .slot_valid (slot_valid),
    .slot_ready (slot_ready)
  );

  ////////////////////
  // One wrapper per slot

  for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
    core_wrapper wrapper (
      .clk        (clk),
      .arst_n     (arst_n),
      .core_reset (core_reset[i]),
      .desc       (slot_desc),
      .desc_valid (slot_valid[i]),
      .desc_ready (slot_ready[i]),
      .res        (res_ch[i].res),
      .res_valid  (res_ch[i].valid),
      .res_ready  (res_ready[i]),
      .count      (counts[i])
    );
  end

  result_collect #(
    .NUM_CORES (NUM_CORES)
  ) collect (
    .clk          (clk),
    .arst_n       (arst_n),
    .res_ch       (res_ch),
    .res_ready    (res_ready),
    .counts       (counts),
    .status_sel   (status_sel),
    .out_res      (out_res),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .status_count (status_count)
  );

endmodule

// File: bench/tb_pr_cluster.sv
`timescale 1ns/1ps

module tb_pr_cluster;

  import pr_pkg::*;

  localparam int NUM_CORES  = 4;
  localparam int WAIT_LIMIT = 2000;

  logic                 clk;
  logic                 arst_n;
  desc_t                in_desc;
  logic                 in_valid;
  logic                 in_ready;
  res_t                 out_res;
  logic                 out_valid;
  logic                 out_ready;
  logic [NUM_CORES-1:0] core_reset;
  logic [SLOT_W-1:0]    status_sel;
  logic [COUNT_W-1:0]   status_count;

  // Expected results per slot and the head of each queue
  res_t               exp_q [NUM_CORES][$];
  res_t               head [NUM_CORES];
  logic               head_ok [NUM_CORES];
  logic [COUNT_W-1:0] exp_count [NUM_CORES];
  int                 pending;

  res_t               exp_now;
  logic               exp_ok;
  logic               out_fire;
  logic               out_fire_q;
  logic [SLOT_W-1:0]  out_slot_q;
  logic               stall_mode;
  logic               cnt_chk;
  logic [COUNT_W-1:0] cnt_exp;
  logic               drain_chk;
  int                 errors;
  int                 test_errors;
  int                 tests_ok;
  int                 tests_bad;

  pr_cluster_top #(
    .NUM_CORES (NUM_CORES)
  ) dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_desc      (in_desc),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .out_res      (out_res),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .core_reset   (core_reset),
    .status_sel   (status_sel),
    .status_count (status_count)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    #1;
    out_ready = stall_mode ? 1'($urandom_range(1, 0)) : 1'b1;
  end

  assign out_fire = out_valid && out_ready;

  always_comb begin
    exp_now = head[out_res.desc.slot];
    exp_ok  = head_ok[out_res.desc.slot];
  end

  ////////////////////
  // Result checks

  always @(negedge clk) begin
    out_fire_q = out_fire;
    out_slot_q = out_res.desc.slot;
  end

  always @(posedge clk) begin
    if (out_fire_q && exp_q[out_slot_q].size() != 0) begin
      void'(exp_q[out_slot_q].pop_front());
      pending--;
      refresh_heads();
    end
  end

  a_res_expected: assert property (@(posedge clk) disable iff (!arst_n)
    out_fire |-> exp_ok)
    else begin
      $display("Result from slot %0d with nothing expected", $sampled(out_res.desc.slot));
      errors++;
    end

  a_res_header: assert property (@(posedge clk) disable iff (!arst_n)
    (out_fire && exp_ok) |-> (out_res.desc[63:32] == exp_now.desc[63:32]))
    else begin
      $display("Mismatch out_res.desc[63:32]: got %h expected %h",
               $sampled(out_res.desc[63:32]), $sampled(exp_now.desc[63:32]));
      errors++;
    end

  a_res_payload: assert property (@(posedge clk) disable iff (!arst_n)
    (out_fire && exp_ok) |-> (out_res.desc.payload == exp_now.desc.payload))
    else begin
      $display("Mismatch out_res.desc.payload: got %h expected %h",
               $sampled(out_res.desc.payload), $sampled(exp_now.desc.payload));
      errors++;
    end

  a_res_second: assert property (@(posedge clk) disable iff (!arst_n)
    (out_fire && exp_ok) |-> (out_res.second == exp_now.second))
    else begin
      $display("Mismatch out_res.second: got %h expected %h",
               $sampled(out_res.second), $sampled(exp_now.second));
      errors++;
    end

  a_status: assert property (@(posedge clk) disable iff (!arst_n)
    cnt_chk |-> (status_count == cnt_exp))
    else begin
      $display("Mismatch status_count: got %h expected %h",
               $sampled(status_count), $sampled(cnt_exp));
      errors++;
    end

  a_drained: assert property (@(posedge clk) disable iff (!arst_n)
    drain_chk |-> (pending == 0))
    else begin
      $display("Results still expected after drain: %0d left", $sampled(pending));
      errors++;
    end

  ////////////////////
  // Model and stimulus

  task automatic refresh_heads();
    for (int s = 0; s < NUM_CORES; s++) begin
      head_ok[s] = (exp_q[s].size() != 0);
      head[s]    = head_ok[s] ? exp_q[s][0] : '0;
    end
  endtask

  task automatic push_expected(res_t r);
    exp_q[r.desc.slot].push_back(r);
    pending++;
  endtask

  task automatic model_accept(desc_t d);
    res_t        r;
    logic [63:0] sum;
    r.second = 1'b0;
    r.desc   = d;
    exp_count[d.slot] = exp_count[d.slot] + 16'd1;
    case (d.op)
      OP_ADD: begin
        sum            = 64'(d.payload) + 64'(d.imm);
        r.desc.payload = 32'(sum % 64'h1_0000_0000);
        push_expected(r);
      end
      OP_DUP: begin
        push_expected(r);
        r.second = 1'b1;
        push_expected(r);
      end
      OP_DROP: ;
      default: push_expected(r);
    endcase
    refresh_heads();
  endtask

  // Called 1 ns after an edge, returns 1 ns after the transfer edge
  task automatic send_desc(logic [SLOT_W-1:0] slot, op_e op);
    desc_t d;
    int    n;
    d.slot    = slot;
    d.op      = op;
    d.tag     = 12'($urandom);
    d.imm     = 16'($urandom);
    d.payload = $urandom;
    in_desc   = d;
    in_valid  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!in_ready && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!in_ready) begin
      $display("Timeout waiting for in_ready on slot %0d", slot);
      errors++;
    end else begin
      @(posedge clk);
      model_accept(d);
    end
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    @(negedge clk);
    while ((pending != 0 || out_valid) && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (pending != 0 || out_valid) begin
      $display("Timeout waiting for results to drain, %0d outstanding", pending);
    end
    // Late extras would show up here
    repeat (8) @(posedge clk);
    #1;
    drain_chk = 1'b1;
    @(posedge clk);
    #1;
    drain_chk = 1'b0;
  endtask

  task automatic check_counts();
    for (int s = 0; s < NUM_CORES; s++) begin
      @(posedge clk);
      #1;
      status_sel = SLOT_W'(s);
      cnt_exp    = exp_count[s];
      @(posedge clk);
      #1;
      cnt_chk = 1'b1;
      @(posedge clk);
      #1;
      cnt_chk = 1'b0;
    end
  endtask

  task automatic report_test(int num, string name);
    if (errors == test_errors) begin
      tests_ok++;
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", num, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  initial begin
    #2ms;
    $display("Timeout: simulation did not finish");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    void'($urandom(32'hef4e));
    clk = 1'b0;
    arst_n = 1'b0;
    in_desc = '0;
    in_valid = 1'b0;
    out_ready = 1'b1;
    core_reset = '0;
    status_sel = '0;
    stall_mode = 1'b0;
    cnt_chk = 1'b0;
    cnt_exp = '0;
    drain_chk = 1'b0;
    out_fire_q = 1'b0;
    out_slot_q = '0;
    pending = 0;
    errors = 0;
    test_errors = 0;
    tests_ok = 0;
    tests_bad = 0;
    for (int s = 0; s < NUM_CORES; s++) begin
      exp_count[s] = '0;
    end
    refresh_heads();
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    for (int s = 0; s < NUM_CORES; s++) begin
      repeat (3) send_desc(SLOT_W'(s), OP_PASS);
    end
    wait_drain();
    report_test(1, "pass");

    for (int i = 0; i < 16; i++) begin
      send_desc(SLOT_W'(i % NUM_CORES), OP_ADD);
    end
    wait_drain();
    report_test(2, "add");

    for (int i = 0; i < 12; i++) begin
      send_desc(SLOT_W'(i % NUM_CORES), OP_DUP);
    end
    wait_drain();
    report_test(3, "duplicate");

    for (int i = 0; i < 10; i++) begin
      send_desc(SLOT_W'(i % NUM_CORES), OP_DROP);
    end
    wait_drain();
    check_counts();
    report_test(4, "drop and counts");

    stall_mode = 1'b1;
    for (int i = 0; i < 300; i++) begin
      send_desc(SLOT_W'($urandom_range(NUM_CORES - 1, 0)), op_e'($urandom_range(3, 0)));
    end
    stall_mode = 1'b0;
    wait_drain();
    check_counts();
    report_test(5, "random with stalls");

    // Slot 2 is idle here
    core_reset = 4'b0100;
    @(posedge clk);
    #1;
    core_reset = '0;
    exp_count[2] = '0;
    repeat (4) @(posedge clk);
    #1;
    check_counts();
    for (int i = 0; i < 12; i++) begin
      send_desc(SLOT_W'(i % NUM_CORES), op_e'($urandom_range(2, 0)));
    end
    wait_drain();
    check_counts();
    report_test(6, "core reset");

    $display("tests: %0d passed, %0d failed, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: flist.f
verilog/pr_pkg.sv
verilog/pipe_reg.sv
verilog/desc_engine.sv
verilog/core_wrapper.sv
verilog/desc_dispatch.sv
verilog/result_collect.sv
verilog/pr_cluster_top.sv
bench/tb_pr_cluster.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pr_cluster
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "\*\* FAIL \*\*" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "\*\* PASS \*\*" $(LOG) || (echo "no result in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
